// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f uart_loopback_top.f --top-module uart_loopback_tb -Mdir obj_dir
	./obj_dir/Vuart_loopback_tb | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: loopback_tester.sv
// Self-test phase machine that sends command bytes on credit and checks their echoes.
`include "uart_link_consts.svh"

module loopback_tester (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx_done,
    input  logic [7:0] data_received,
    input  logic       parity_error,
    input  logic       tx_credit,
    output logic       start_tx,
    output logic [7:0] data_to_tx,
    output logic       led_red,
    output logic       led_green,
    output logic       led_blue
);

    localparam int PHASE_W = $clog2(`INIT_CYCLES + `SEND_CYCLES + `WAIT_CYCLES);
    localparam logic [PHASE_W-1:0] INIT_LAST = PHASE_W'(`INIT_CYCLES - 1);
    localparam logic [PHASE_W-1:0] SEND_LAST = PHASE_W'(`SEND_CYCLES - 1);
    localparam logic [PHASE_W-1:0] WAIT_LAST = PHASE_W'(`WAIT_CYCLES - 1);
    localparam int CREDIT_W = $clog2(`TX_CREDITS + 1);
    localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(`TX_CREDITS);
    localparam logic LED_ON  = 1'b0;
    localparam logic LED_OFF = 1'b1;

    uart_link_pkg::tester_state_e state;
    uart_link_pkg::uart_cmd_e     cmd;         // Next byte of the rotation.
    logic [PHASE_W-1:0]  phase_cnt;
    logic [CREDIT_W-1:0] credits;
    logic [7:0]          expected;             // Last byte issued.
    logic                echo_valid;

    // No issue on the last send cycle, so every frame starts inside UART_SEND.
    assign start_tx   = (state == uart_link_pkg::UART_SEND) && (credits != '0) &&
                        (phase_cnt != SEND_LAST);
    assign data_to_tx = cmd;
    assign echo_valid = rx_done && (state == uart_link_pkg::UART_SEND ||
                                    state == uart_link_pkg::END_TX);

    // ========================================
    // Phase sequencing
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= uart_link_pkg::INIT;
            phase_cnt <= '0;
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
            case (state)
                uart_link_pkg::INIT: begin
                    if (phase_cnt == INIT_LAST) begin
                        state     <= uart_link_pkg::UART_SEND;
                        phase_cnt <= '0;
                    end
                end
                uart_link_pkg::UART_SEND: begin
                    if (phase_cnt == SEND_LAST) begin
                        state     <= uart_link_pkg::END_TX;
                        phase_cnt <= '0;
                    end
                end
                uart_link_pkg::END_TX: begin
                    state     <= uart_link_pkg::WAIT;
                    phase_cnt <= '0;
                end
                default: begin
                    if (phase_cnt == WAIT_LAST) begin
                        state     <= uart_link_pkg::INIT;   // Restart the cycle.
                        phase_cnt <= '0;
                    end
                end
            endcase
        end
    end

    // Credits come back even after UART_SEND, from a frame still in flight.
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CREDIT_INIT;
        end else begin
            case ({start_tx, tx_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || state == uart_link_pkg::INIT) begin
            cmd <= uart_link_pkg::CMD_TURN_ON;      // Rotation restarts each round.
        end else if (start_tx) begin
            case (cmd)
                uart_link_pkg::CMD_TURN_ON:  cmd <= uart_link_pkg::CMD_TURN_OFF;
                uart_link_pkg::CMD_TURN_OFF: cmd <= uart_link_pkg::CMD_TOGGLE;
                default:                     cmd <= uart_link_pkg::CMD_TURN_ON;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_tx) begin
            expected <= cmd;
        end
    end

    // ========================================
    // LED indication (active low)
    // ========================================
    always_ff @(posedge clk) begin
        if (reset || state == uart_link_pkg::INIT) begin
            led_red   <= LED_OFF;
            led_green <= LED_OFF;
            led_blue  <= LED_OFF;
        end else begin
            led_blue <= (state == uart_link_pkg::UART_SEND) ? LED_ON : LED_OFF;
            if (echo_valid) begin
                if (data_received == expected && !parity_error) begin
                    led_red <= ~led_red;            // Good echo.
                end else begin
                    led_red   <= LED_OFF;
                    led_green <= LED_ON;            // Held until INIT.
                end
            end
        end
    end

endmodule

// File: uart_link_consts.svh
// Timing and credit constants for the UART loopback self-test.
`ifndef UART_LINK_CONSTS_SVH
`define UART_LINK_CONSTS_SVH

// Clock cycles per serial bit.
`define CLKS_PER_BIT 8

// Phase lengths in clock cycles.
`define INIT_CYCLES 40
`define SEND_CYCLES 600
`define WAIT_CYCLES 40

// One credit per transmit slot.
`define TX_CREDITS 1

`endif

// File: uart_link_pkg.sv
// Shared state and command types for the UART loopback self-test.
package uart_link_pkg;

    // ========================================
    // Self-test phases
    // ========================================
    typedef enum logic [1:0] {
        INIT,        // LEDs off, line idle.
        UART_SEND,   // Bytes issued against credits.
        END_TX,      // Single cycle between send and wait.
        WAIT         // Quiet line before the next round.
    } tester_state_e;

    // Command bytes sent in rotation.
    typedef enum logic [7:0] {
        CMD_TURN_ON  = 8'hAA,
        CMD_TURN_OFF = 8'h55,
        CMD_TOGGLE   = 8'hC3
    } uart_cmd_e;

    // ========================================
    // Serial framing states
    // ========================================
    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
    } rx_state_e;

endpackage

// File: uart_loopback_tb.sv
// Testbench for the UART loopback self-test that closes the serial loop and corrupts one frame.
`include "uart_link_consts.svh"

module uart_loopback_tb;

    localparam int FRAME_CYCLES   = 11 * `CLKS_PER_BIT;
    localparam int HALF_BIT       = `CLKS_PER_BIT / 2;
    localparam int SEND_FIRST     = `INIT_CYCLES;                 // First UART_SEND position.
    localparam int SEND_END       = `INIT_CYCLES + `SEND_CYCLES;  // END_TX position.
    localparam int ROUND_CYCLES   = SEND_END + 1 + `WAIT_CYCLES;
    localparam int END_CYCLE      = 2 * ROUND_CYCLES + SEND_FIRST; // Through the third INIT.
    localparam int TIMEOUT_CYCLES = 3 * ROUND_CYCLES + 200;
    localparam int FAULT_BIT      = 3;

    logic clk;
    logic reset;
    logic rx;
    logic tx;
    logic tx_busy;
    logic rx_done;
    logic parity_error;
    logic led_red;
    logic led_green;
    logic led_blue;

    integer      seed;
    int          fault_idx;       // Frame of the second send phase to corrupt.
    int          timeout_cnt;
    int          cycle_num;       // Clock edges since reset release.
    int          pos;
    int          round;
    int          frame_cyc;
    int          frame_idx;
    int          cur_idx;
    int          idle_run;
    int          fault_echoes;
    logic        edge_reset;
    logic        in_frame;
    logic        cur_fault;
    logic        last_fault;
    logic        echo_pending;    // Decoded frame still waiting for its rx_done.
    logic        flip;
    logic [10:0] bits;            // Line samples of the frame in progress.
    logic [7:0]  last_byte;
    logic [7:0]  echo_byte;
    logic        exp_red;
    logic        exp_green;

    uart_loopback_top DUT (
        .clk          (clk),
        .reset        (reset),
        .rx           (rx),
        .tx           (tx),
        .tx_busy      (tx_busy),
        .rx_done      (rx_done),
        .parity_error (parity_error),
        .led_red      (led_red),
        .led_green    (led_green),
        .led_blue     (led_blue)
    );

    task automatic value_error(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("error %s expected %0h actual %0h", test, expected, actual);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic run_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [7:0] rotation_byte(input int idx);
        case (idx % 3)
            0:       return uart_link_pkg::CMD_TURN_ON;
            1:       return uart_link_pkg::CMD_TURN_OFF;
            default: return uart_link_pkg::CMD_TOGGLE;
        endcase
    endfunction

    // ========================================
    // Clock, reset and timeout
    // ========================================
    always #5 clk = ~clk;

    initial begin
        clk       = 1'b0;
        rx        = 1'b1;                              // Idle line.
        reset     = 1'b1;
        seed      = 32'h876a2a11;
        fault_idx = $unsigned($random(seed)) % 5;      // Echo lands inside UART_SEND.
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
    end

    always @(posedge clk) begin
        timeout_cnt = timeout_cnt + 1;
        if (timeout_cnt >= TIMEOUT_CYCLES) begin
            $display("the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(rx_done && $past(rx_done)))
        else value_error("rx_done_pulse", 0, 32'($sampled(rx_done)));
    assert property (@(posedge clk) disable iff (reset) tx_busy || tx)
        else value_error("idle_line_high", 1, 32'($sampled(tx)));

    // ========================================
    // Line loop, frame decoder and checks
    // ========================================
    always @(posedge clk) begin
        edge_reset = reset;
        #1;
        if (edge_reset) begin
            cycle_num    = 0;
            in_frame     = 1'b0;
            frame_cyc    = 0;
            frame_idx    = 0;
            idle_run     = 0;
            fault_echoes = 0;
            cur_fault    = 1'b0;
            last_fault   = 1'b0;
            echo_pending = 1'b0;
            exp_red      = 1'b1;
            exp_green    = 1'b1;
        end else begin
            cycle_num = cycle_num + 1;
        end
        pos   = cycle_num % ROUND_CYCLES;
        round = cycle_num / ROUND_CYCLES;

        if (cycle_num == END_CYCLE) begin
            assert (!echo_pending)
                else run_failure("the last frame of the run was never echoed");
            if (fault_echoes == 1) begin
                $display("TEST PASS");
                $finish;
            end else begin
                run_failure($sformatf("the corrupted frame was echoed %0d times", fault_echoes));
            end
        end else begin
            if (pos == SEND_FIRST) begin
                frame_idx = 0;                         // Rotation restarts.
            end
            if (in_frame) begin
                frame_cyc = frame_cyc + 1;
                if (frame_cyc == FRAME_CYCLES) begin
                    in_frame = 1'b0;
                end
            end
            if (!in_frame && tx === 1'b0) begin
                assert (pos > SEND_FIRST && pos < SEND_END)
                    else run_failure($sformatf("a frame started outside UART_SEND at %0d", pos));
                assert (frame_idx != 0 || round == 0 || idle_run >= `WAIT_CYCLES)
                    else run_failure($sformatf("the line was quiet only %0d cycles", idle_run));
                assert (!echo_pending)
                    else run_failure("a frame started before the previous one was echoed");
                in_frame  = 1'b1;
                frame_cyc = 0;
                cur_idx   = frame_idx;
                cur_fault = (round == 1) && (frame_idx == fault_idx);
                frame_idx = frame_idx + 1;
            end
            idle_run = in_frame ? 0 : idle_run + 1;

            if (in_frame) begin
                assert (tx_busy === 1'b1) else value_error("tx_busy_in_frame", 1, 32'(tx_busy));
                if (frame_cyc % `CLKS_PER_BIT == HALF_BIT) begin
                    bits = {tx, bits[10:1]};           // LSB first.
                end
                if (frame_cyc >= FRAME_CYCLES - `CLKS_PER_BIT) begin
                    assert (tx === 1'b1) else value_error("stop_bit_held", 1, 32'(tx));
                end
                if (frame_cyc == FRAME_CYCLES - HALF_BIT) begin
                    assert (bits[0] === 1'b0) else value_error("start_bit", 0, 32'(bits[0]));
                    assert (bits[9] === ^bits[8:1])
                        else value_error("even_parity", 32'(^bits[8:1]), 32'(bits[9]));
                    assert (bits[8:1] === rotation_byte(cur_idx))
                        else value_error("byte_order", 32'(rotation_byte(cur_idx)),
                                         32'(bits[8:1]));
                    last_byte    = bits[8:1];
                    last_fault   = cur_fault;
                    echo_pending = 1'b1;
                end
            end else begin
                assert (tx_busy === 1'b0) else value_error("tx_busy_idle", 0, 32'(tx_busy));
            end

            // Data bit 3 of the chosen frame is inverted on its way back.
            flip = in_frame && cur_fault &&
                   frame_cyc >= `CLKS_PER_BIT * (FAULT_BIT + 1) &&
                   frame_cyc <  `CLKS_PER_BIT * (FAULT_BIT + 2);
            rx = tx ^ flip;

            if (rx_done) begin
                assert (echo_pending)
                    else run_failure("rx_done came with no frame awaiting its echo");
                echo_pending = 1'b0;
                echo_byte = last_fault ? (last_byte ^ 8'(1 << FAULT_BIT)) : last_byte;
                assert (parity_error === last_fault)
                    else value_error("echo_parity", 32'(last_fault), 32'(parity_error));
                assert (DUT.data_received === echo_byte)
                    else value_error("echo_data", 32'(echo_byte), 32'(DUT.data_received));
                if (last_fault) begin
                    fault_echoes = fault_echoes + 1;
                end
            end

            if (pos < SEND_FIRST) begin
                assert (tx === 1'b1) else value_error("init_tx_idle", 1, 32'(tx));
                assert (rx_done === 1'b0) else value_error("init_rx_done", 0, 32'(rx_done));
            end
            assert (led_red === exp_red) else value_error("led_red", 32'(exp_red), 32'(led_red));
            assert (led_green === exp_green)
                else value_error("led_green", 32'(exp_green), 32'(led_green));
            if (pos > SEND_FIRST && pos < SEND_END) begin
                assert (led_blue === 1'b0) else value_error("led_blue_send", 0, 32'(led_blue));
            end else if (pos != SEND_END) begin
                assert (led_blue === 1'b1) else value_error("led_blue_idle", 1, 32'(led_blue));
            end

            // LEDs are registered, so the model gives next cycle's values.
            if (pos < SEND_FIRST) begin
                exp_red   = 1'b1;
                exp_green = 1'b1;
            end else if (rx_done && pos <= SEND_END) begin
                if (last_fault) begin
                    exp_red   = 1'b1;
                    exp_green = 1'b0;
                end else begin
                    exp_red = ~exp_red;
                end
            end
        end
    end

endmodule

// File: uart_loopback_top.f
+incdir+.
uart_link_pkg.sv
uart_tx.sv
uart_rx.sv
loopback_tester.sv
uart_loopback_top.sv
uart_loopback_tb.sv

// File: uart_loopback_top.sv
// Top level of the UART loopback self-test with the tester, transmitter and receiver.
module uart_loopback_top (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic tx,
    output logic tx_busy,
    output logic rx_done,
    output logic parity_error,
    output logic led_red,
    output logic led_green,
    output logic led_blue
);

    logic       start_tx;
    logic [7:0] data_to_tx;
    logic       tx_credit;
    logic [7:0] data_received;

    loopback_tester tester (
        .clk           (clk),
        .reset         (reset),
        .rx_done       (rx_done),
        .data_received (data_received),
        .parity_error  (parity_error),
        .tx_credit     (tx_credit),
        .start_tx      (start_tx),
        .data_to_tx    (data_to_tx),
        .led_red       (led_red),
        .led_green     (led_green),
        .led_blue      (led_blue)
    );

    uart_tx transmitter (
        .clk        (clk),
        .reset      (reset),
        .start_tx   (start_tx),
        .data_to_tx (data_to_tx),
        .tx         (tx),
        .tx_busy    (tx_busy),         // Test pin.
        .tx_credit  (tx_credit)
    );

    uart_rx receiver (
        .clk           (clk),
        .reset         (reset),
        .rx            (rx),           // Looped back off chip.
        .data_received (data_received),
        .rx_done       (rx_done),
        .parity_error  (parity_error)
    );

endmodule

// File: uart_rx.sv
// Serial receiver that samples at bit centers and checks parity and the stop bit.
`include "uart_link_consts.svh"

module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] data_received,
    output logic       rx_done,
    output logic       parity_error
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`CLKS_PER_BIT / 2 - 1);

    uart_link_pkg::rx_state_e state;
    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    logic             parity_bad;    // Parity of the frame in progress.
    logic             sample;

    // Full bit period from the start-bit center lands on each later center.
    assign sample = (bit_cnt == BIT_LAST);

    // ========================================
    // Input synchronizer
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // ========================================
    // Frame state machine
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= uart_link_pkg::RX_IDLE;
            bit_cnt      <= '0;
            bit_idx      <= '0;
            rx_done      <= 1'b0;
            parity_error <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            case (state)
                uart_link_pkg::RX_IDLE: begin
                    bit_cnt <= '0;
                    if (!rx_sync) begin
                        state <= uart_link_pkg::RX_START;   // Falling edge.
                    end
                end
                uart_link_pkg::RX_START: begin
                    if (bit_cnt == HALF_LAST) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        if (!rx_sync) begin
                            state <= uart_link_pkg::RX_DATA;
                        end else begin
                            state <= uart_link_pkg::RX_IDLE;    // Glitch.
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                uart_link_pkg::RX_DATA: begin
                    if (sample) begin
                        bit_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= uart_link_pkg::RX_PARITY;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                uart_link_pkg::RX_PARITY: begin
                    if (sample) begin
                        bit_cnt <= '0;
                        state   <= uart_link_pkg::RX_STOP;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                uart_link_pkg::RX_STOP: begin
                    if (sample) begin
                        bit_cnt <= '0;
                        state   <= uart_link_pkg::RX_IDLE;
                        if (rx_sync) begin                 // Framing error drops it.
                            rx_done      <= 1'b1;
                            parity_error <= parity_bad;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= uart_link_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // Data arrives LSB first into the top of the register.
    always_ff @(posedge clk) begin
        if (state == uart_link_pkg::RX_DATA && sample) begin
            data_received <= {rx_sync, data_received[7:1]};
        end
        if (state == uart_link_pkg::RX_PARITY && sample) begin
            parity_bad <= rx_sync ^ (^data_received);   // Even parity check.
        end
    end

endmodule

// File: uart_tx.sv
// Serial transmitter that frames each byte with even parity and returns a credit per frame.
`include "uart_link_consts.svh"

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic       start_tx,
    input  logic [7:0] data_to_tx,
    output logic       tx,
    output logic       tx_busy,
    output logic       tx_credit
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`CLKS_PER_BIT - 1);

    uart_link_pkg::tx_state_e state;
    logic [CNT_W-1:0] bit_cnt;     // Cycle within the current bit.
    logic [2:0]       bit_idx;     // Data bit on the line.
    logic [7:0]       shift_reg;
    logic             parity_bit;
    logic             bit_end;

    assign bit_end   = (bit_cnt == BIT_LAST);
    assign tx_busy   = (state != uart_link_pkg::TX_IDLE);
    assign tx_credit = (state == uart_link_pkg::TX_STOP) && bit_end;   // Last stop cycle.

    // ========================================
    // Frame sequencer
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= uart_link_pkg::TX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;                  // Idle line.
        end else begin
            if (state == uart_link_pkg::TX_IDLE || bit_end) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end

            case (state)
                uart_link_pkg::TX_IDLE: begin
                    if (start_tx) begin
                        tx    <= 1'b0;        // Start bit.
                        state <= uart_link_pkg::TX_START;
                    end
                end
                uart_link_pkg::TX_START: begin
                    if (bit_end) begin
                        tx      <= shift_reg[0];
                        bit_idx <= '0;
                        state   <= uart_link_pkg::TX_DATA;
                    end
                end
                uart_link_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            tx    <= parity_bit;
                            state <= uart_link_pkg::TX_PARITY;
                        end else begin
                            tx      <= shift_reg[0];
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                uart_link_pkg::TX_PARITY: begin
                    if (bit_end) begin
                        tx    <= 1'b1;        // Stop bit.
                        state <= uart_link_pkg::TX_STOP;
                    end
                end
                uart_link_pkg::TX_STOP: begin
                    if (bit_end) begin
                        state <= uart_link_pkg::TX_IDLE;
                    end
                end
                default: begin
                    tx    <= 1'b1;
                    state <= uart_link_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // LSB leaves first, so the register shifts right at each bit boundary.
    always_ff @(posedge clk) begin
        if (state == uart_link_pkg::TX_IDLE && start_tx) begin
            shift_reg  <= data_to_tx;
            parity_bit <= ^data_to_tx;        // Even parity.
        end else if (bit_end && (state == uart_link_pkg::TX_START ||
                                 state == uart_link_pkg::TX_DATA)) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

endmodule
